// ==== board_pkg.sv ====
//**************************************************************************
// board level definitions: cell marks, board shape and the eight
// winning lines of the tic-tac-toe grid
//**************************************************************************
package board_pkg;

  localparam int num_cells  = 9;  // 3x3 grid
  localparam int cell_idx_w = 4;  // index range 0..15, only 0..8 are real
  localparam int num_lines  = 8;  // 3 rows, 3 columns, 2 diagonals

  // what a cell holds
  typedef enum logic [1:0] {
    mark_empty    = 2'b00,
    mark_player   = 2'b01,
    mark_computer = 2'b10
  } mark_t;

  // cell 0 is the top left and numbering runs row by row
  // so cell 4 is the centre
  typedef mark_t [num_cells-1:0] board_t;

  // three cell indices per line
  localparam int unsigned win_lines [num_lines][3] = '{
    '{0, 1, 2},  // top row
    '{3, 4, 5},  // middle row
    '{6, 7, 8},  // bottom row
    '{0, 3, 6},  // left column
    '{1, 4, 7},  // centre column
    '{2, 5, 8},  // right column
    '{0, 4, 8},  // main diagonal
    '{2, 4, 6}   // anti diagonal
  };

endpackage

// ==== game_pkg.sv ====
//**************************************************************************
// game level definitions: turn states of the referee and the
// combined game result seen by the controller
//**************************************************************************
package game_pkg;

  import board_pkg::*;  // marks come from the board package

  // referee states
  // no separate idle state, the player simply waits for play
  typedef enum logic [1:0] {
    st_player_turn   = 2'b00,
    st_computer_turn = 2'b01,
    st_game_done     = 2'b10  // sticky until reset
  } turn_t;

  // verdict of both checkers folded together
  // done covers a completed line as well as a full board
  typedef struct packed {
    logic  done;    // win or full
    mark_t winner;  // owner of the winning line, else empty
  } result_t;

endpackage

// ==== judge_if.sv ====
//**************************************************************************
// board verdicts from the win and move checkers to the controller
//**************************************************************************
interface judge_if import board_pkg::*; ();

  logic  win;          // some line holds three equal marks
  mark_t winner;       // owner of first completed line
  logic  full;         // no empty cell left
  logic  player_ok;    // player's cell is real and empty
  logic  computer_ok;  // computer's cell is real and empty

  // all levels, combinational from board and indices
  modport win_src (output win, winner);

  modport move_src (output full, player_ok, computer_ok);

  modport sink (input win, winner, full, player_ok, computer_ok);

endinterface

// ==== board_regs.sv ====
//**************************************************************************
// nine cell registers, one accepted move written per cycle
//**************************************************************************
module board_regs import board_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  write_en,    // accepted move this cycle
  input  logic [cell_idx_w-1:0] write_cell,  // target cell
  input  mark_t                 write_mark,  // mark of the moving side
  output board_t                board
);

  // cell storage
  // reset gives an empty board for a new game
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < num_cells; i++) begin
        board[i] <= mark_empty;
      end
    end else if (write_en) begin
      board[write_cell] <= write_mark;  // single cell per move
    end
  end

  // the controller only writes after move_checker cleared the cell
  // so an overwrite means the verdict and the write got out of step
  a_no_overwrite: assert property (
    @(posedge clk) disable iff (reset)
    write_en |-> board[write_cell] == mark_empty
  ) else $error("board_regs: write to occupied cell %0d", write_cell);

  // a move always leaves a mark behind
  a_mark_valid: assert property (
    @(posedge clk) disable iff (reset)
    write_en |-> write_mark != mark_empty
  ) else $error("board_regs: write of empty mark");

endmodule

// ==== win_checker.sv ====
//**************************************************************************
// line scan over the eight winning lines, finds completed line and owner
//**************************************************************************
module win_checker import board_pkg::*; (
  input  board_t          board,
  judge_if.win_src        judge
);

  logic [num_lines-1:0] line_hit;             // one bit per line
  mark_t                line_owner [num_lines]; // mark in first cell of line

  // three equal non-empty marks complete a line
  always_comb begin
    for (int i = 0; i < num_lines; i++) begin
      line_owner[i] = board[win_lines[i][0]];
      line_hit[i]   = (line_owner[i] != mark_empty) &&
                      (board[win_lines[i][1]] == line_owner[i]) &&
                      (board[win_lines[i][2]] == line_owner[i]);
    end
  end

  assign judge.win = |line_hit;

  // owner of the lowest numbered hit
  // scan runs downwards so line 0 has the last word
  // only one side can really own lines at once
  always_comb begin
    judge.winner = mark_empty;
    for (int i = num_lines - 1; i >= 0; i--) begin
      if (line_hit[i]) begin
        judge.winner = line_owner[i];
      end
    end
  end

endmodule

// ==== move_checker.sv ====
//**************************************************************************
// legality of each side's requested cell and full board detection
//**************************************************************************
module move_checker import board_pkg::*; (
  input  board_t                board,
  input  logic [cell_idx_w-1:0] player_cell,    // index from player
  input  logic [cell_idx_w-1:0] computer_cell,  // index from computer
  judge_if.move_src             judge
);

  // cell must exist and be empty
  // indices 9..15 never name a cell
  function automatic logic cell_free(input board_t b,
                                     input logic [cell_idx_w-1:0] idx);
    if (idx >= num_cells) begin
      return 1'b0;  // out of range
    end
    return b[idx] == mark_empty;
  endfunction

  // turn and game state are left to the controller
  assign judge.player_ok   = cell_free(board, player_cell);
  assign judge.computer_ok = cell_free(board, computer_cell);

  // full when no empty cell remains
  always_comb begin
    judge.full = 1'b1;
    for (int i = 0; i < num_cells; i++) begin
      if (board[i] == mark_empty) begin
        judge.full = 1'b0;  // at least one gap
      end
    end
  end

endmodule

// ==== game_controller.sv ====
//**************************************************************************
// turn FSM: combines checker verdicts, issues board writes,
// alternates sides and holds the game over until reset
//**************************************************************************
module game_controller import board_pkg::*, game_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  play,           // player strobe
  input  logic                  pc,             // computer strobe
  input  logic [cell_idx_w-1:0] player_cell,
  input  logic [cell_idx_w-1:0] computer_cell,
  judge_if.sink                 judge,
  output logic                  write_en,
  output logic [cell_idx_w-1:0] write_cell,
  output mark_t                 write_mark,
  output logic                  game_over,
  output logic                  player_turn
);

  turn_t   state;
  turn_t   next_state;
  result_t result;  // folded verdict

  assign result.done   = judge.win | judge.full;
  assign result.winner = judge.winner;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_player_turn;  // player always opens
    end else begin
      state <= next_state;
    end
  end

  // next state and write request
  // a finished board blocks every strobe in the same cycle
  always_comb begin
    next_state = state;
    write_en   = 1'b0;
    write_cell = player_cell;  // default side
    write_mark = mark_player;
    unique case (state)
      st_player_turn: begin
        if (result.done) begin
          next_state = st_game_done;
        end else if (play && judge.player_ok) begin
          write_en   = 1'b1;
          next_state = st_computer_turn;  // hand over
        end
      end
      st_computer_turn: begin
        write_cell = computer_cell;
        write_mark = mark_computer;
        if (result.done) begin
          next_state = st_game_done;
        end else if (pc && judge.computer_ok) begin
          write_en   = 1'b1;
          next_state = st_player_turn;
        end
      end
      default: begin
        next_state = st_game_done;  // only reset leaves
      end
    endcase
  end

  assign game_over   = (state == st_game_done);
  assign player_turn = (state == st_player_turn);

  // no board change once the game is decided
  a_no_write_done: assert property (
    @(posedge clk) disable iff (reset)
    game_over |-> !write_en
  ) else $error("game_controller: write after game over");

  // a reported line always has an owner
  a_win_owner: assert property (
    @(posedge clk) disable iff (reset)
    judge.win |-> result.winner != mark_empty
  ) else $error("game_controller: win without owner");

endmodule

// ==== tic_tac_toe.sv ====
//**************************************************************************
// tic-tac-toe referee top: board, both checkers and turn FSM
//**************************************************************************
module tic_tac_toe import board_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  play,           // player move strobe
  input  logic                  pc,             // computer move strobe
  input  logic [cell_idx_w-1:0] player_cell,
  input  logic [cell_idx_w-1:0] computer_cell,
  output board_t                board,
  output mark_t                 winner,
  output logic                  game_over,
  output logic                  player_turn
);

  logic                  write_en;
  logic [cell_idx_w-1:0] write_cell;
  mark_t                 write_mark;

  judge_if judge ();  // verdicts to controller

  board_regs u_board_regs (
    .clk        (clk),
    .reset      (reset),
    .write_en   (write_en),
    .write_cell (write_cell),
    .write_mark (write_mark),
    .board      (board)
  );

  // both checkers look at the same board
  win_checker u_win_checker (
    .board (board),
    .judge (judge)
  );

  move_checker u_move_checker (
    .board         (board),
    .player_cell   (player_cell),
    .computer_cell (computer_cell),
    .judge         (judge)
  );

  game_controller u_game_controller (
    .clk           (clk),
    .reset         (reset),
    .play          (play),
    .pc            (pc),
    .player_cell   (player_cell),
    .computer_cell (computer_cell),
    .judge         (judge),
    .write_en      (write_en),
    .write_cell    (write_cell),
    .write_mark    (write_mark),
    .game_over     (game_over),
    .player_turn   (player_turn)
  );

  assign winner = judge.winner;  // live line owner

endmodule

// ==== tb_tic_tac_toe.sv ====
//**************************************************************************
// testbench for the tic-tac-toe referee: clock, reset, random games,
// reference model of the accept rule, value check and watchdog
//**************************************************************************
module tb_tic_tac_toe import board_pkg::*, game_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_games   = 200;
  localparam int game_cycles = 60;   // cycle limit per game
  localparam int tail_cycles = 3;    // extra strobes after game over
  localparam int reset_len   = 4;
  localparam longint timeout_ns = longint'(num_games) * 70 * 10;

  logic                  clk;
  logic                  reset;
  logic                  play;
  logic                  pc;
  logic [cell_idx_w-1:0] player_cell;
  logic [cell_idx_w-1:0] computer_cell;
  board_t                board;
  mark_t                 winner;
  logic                  game_over;
  logic                  player_turn;

  int    seed;
  mark_t model_board [num_cells];  // reference copy of the grid
  turn_t model_turn;
  int    n_moves;      // accepted moves over the run
  int    n_rejects;    // strobes from the side on turn that failed
  int    n_wins;
  int    n_draws;
  int    n_open;       // games cut off at the cycle limit

  tic_tac_toe u_tic_tac_toe (
    .clk           (clk),
    .reset         (reset),
    .play          (play),
    .pc            (pc),
    .player_cell   (player_cell),
    .computer_cell (computer_cell),
    .board         (board),
    .winner        (winner),
    .game_over     (game_over),
    .player_turn   (player_turn)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // compare one value, stop at first difference
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %0h actual %0h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // three cells with the same non-empty mark
  function automatic logic same_three(input int a, input int b, input int c);
    return (model_board[a] != mark_empty) &&
           (model_board[a] == model_board[b]) &&
           (model_board[a] == model_board[c]);
  endfunction

  // owner of a completed line on the model grid, rows then columns
  function automatic mark_t model_winner();
    for (int r = 0; r < 3; r++) begin
      if (same_three(3 * r, 3 * r + 1, 3 * r + 2)) begin
        return model_board[3 * r];
      end
    end
    for (int c = 0; c < 3; c++) begin
      if (same_three(c, c + 3, c + 6)) begin
        return model_board[c];
      end
    end
    if (same_three(0, 4, 8)) begin
      return model_board[0];  // main diagonal
    end
    if (same_three(2, 4, 6)) begin
      return model_board[2];  // anti diagonal
    end
    return mark_empty;
  endfunction

  function automatic logic model_full();
    for (int i = 0; i < num_cells; i++) begin
      if (model_board[i] == mark_empty) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // real cell and still empty
  function automatic logic model_legal(input logic [cell_idx_w-1:0] idx);
    if (idx >= num_cells) begin
      return 1'b0;
    end
    return model_board[idx] == mark_empty;
  endfunction

  // expected board in the packed layout, cell 0 in the low bits
  function automatic logic [31:0] model_packed();
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < num_cells; i++) begin
      v[2 * i +: 2] = model_board[i];
    end
    return v;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < num_cells; i++) begin
      model_board[i] = mark_empty;
    end
    model_turn = st_player_turn;
  endtask

  // accept rule at one rising edge, verdict from the board before it
  task automatic model_step();
    logic decided;
    decided = (model_winner() != mark_empty) || model_full();
    case (model_turn)
      st_player_turn: begin
        if (decided) begin
          model_turn = st_game_done;
        end else if (play && model_legal(player_cell)) begin
          model_board[player_cell] = mark_player;
          model_turn = st_computer_turn;
          n_moves++;
        end else if (play) begin
          n_rejects++;  // occupied or out of range
        end
      end
      st_computer_turn: begin
        if (decided) begin
          model_turn = st_game_done;
        end else if (pc && model_legal(computer_cell)) begin
          model_board[computer_cell] = mark_computer;
          model_turn = st_player_turn;
          n_moves++;
        end else if (pc) begin
          n_rejects++;
        end
      end
      default: begin
        model_turn = st_game_done;  // sticky
      end
    endcase
  endtask

  task automatic check_outputs(input string tag);
    check_value({tag, " board"}, model_packed(), board);
    check_value({tag, " winner"}, model_winner(), winner);
    check_value({tag, " game_over"}, model_turn == st_game_done, game_over);
    check_value({tag, " player_turn"}, model_turn == st_player_turn, player_turn);
  endtask

  // new inputs on the falling edge, indices span the full 4 bits
  task automatic drive_random();
    logic [31:0] r;
    r = $random(seed);
    play          = r[0];
    pc            = r[8];
    player_cell   = r[19:16];
    computer_cell = r[27:24];
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset         = 1'b1;
    play          = 1'b0;
    pc            = 1'b0;
    player_cell   = '0;
    computer_cell = '0;
    repeat (reset_len) @(negedge clk);
    reset = 1'b0;
    model_reset();
  endtask

  // whole run bounded by games times cycles per game
  initial begin
    #(timeout_ns);
    $display("watchdog: run timed out after %0t, a game did not finish", $time);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    int    cycles;
    int    tail;
    string tag;
    reset         = 1'b1;
    play          = 1'b0;
    pc            = 1'b0;
    player_cell   = '0;
    computer_cell = '0;
    seed          = 32'h12a1b4e4;
    n_moves       = 0;
    n_rejects     = 0;
    n_wins        = 0;
    n_draws       = 0;
    n_open        = 0;
    model_reset();
    for (int g = 0; g < num_games; g++) begin
      apply_reset();
      check_outputs($sformatf("game %0d after reset", g));
      cycles = 0;
      tail   = 0;
      while (cycles < game_cycles && tail < tail_cycles) begin
        drive_random();
        @(posedge clk);
        model_step();
        @(negedge clk);  // outputs settled here
        tag = $sformatf("game %0d cycle %0d %s", g, cycles, model_turn.name());
        check_outputs(tag);
        if (model_turn == st_game_done) begin
          tail++;  // strobes past the end must do nothing
        end
        cycles++;
      end
      if (model_turn != st_game_done) begin
        n_open++;
      end else if (model_winner() != mark_empty) begin
        n_wins++;
      end else begin
        n_draws++;
      end
    end
    $display("games %0d wins %0d draws %0d open %0d moves %0d rejected %0d",
             num_games, n_wins, n_draws, n_open, n_moves, n_rejects);
    $display("Test OK");
    $finish;
  end

endmodule

// ==== project.f ====
board_pkg.sv
game_pkg.sv
judge_if.sv
board_regs.sv
win_checker.sv
move_checker.sv
game_controller.sv
tic_tac_toe.sv
tb_tic_tac_toe.sv

// ==== Bender.yml ====
package:
  name: tic_tac_toe

sources:
  - board_pkg.sv
  - game_pkg.sv
  - judge_if.sv
  - board_regs.sv
  - win_checker.sv
  - move_checker.sv
  - game_controller.sv
  - tic_tac_toe.sv
  - target: test
    files:
      - tb_tic_tac_toe.sv
